/* rtl/vid_macros.svh */
`ifndef VID_MACROS_SVH
`define VID_MACROS_SVH

// Display timing, in pixels per line and lines per frame
`define VID_H_ACT   8
`define VID_H_FP    2
`define VID_H_SYNC  2
`define VID_H_BP    2

`define VID_V_ACT   4
`define VID_V_FP    1
`define VID_V_SYNC  1
`define VID_V_BP    1

`define VID_H_TOTAL (`VID_H_ACT + `VID_H_FP + `VID_H_SYNC + `VID_H_BP)
`define VID_V_TOTAL (`VID_V_ACT + `VID_V_FP + `VID_V_SYNC + `VID_V_BP)

// Camera blank detection: href low this long counts as vertical blank
`define VID_LOCK_THRESH 20
`define VID_LOCK_DELAY  5

// FIFO entries, also the initial credit count of the capture stage
`define VID_FIFO_DEPTH 32

`define VID_PIX_W 16

`define VID_X_W $clog2(`VID_H_TOTAL)
`define VID_Y_W $clog2(`VID_V_TOTAL)

`endif

/* rtl/vid_pkg.sv */
`include "vid_macros.svh"

package vid_pkg;

    typedef logic [`VID_PIX_W-1:0] pixel_t;

    // Capture to FIFO write beat
    typedef struct packed {
        logic   valid;
        pixel_t pixel;
    } cam_beat_t;

    // Display beat, syncs active high
    typedef struct packed {
        logic                vsync;
        logic                hsync;
        logic                de;
        logic [`VID_X_W-1:0] x;
        logic [`VID_Y_W-1:0] y;
        pixel_t              pixel;
    } disp_beat_t;

endpackage : vid_pkg

/* rtl/cam_capture.sv */
`timescale 1ns/10ps
`include "vid_macros.svh"

module cam_capture
    import vid_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      cam_href,
    input  pixel_t    cam_data,
    input  logic      credit_ret,
    output cam_beat_t wr,
    output logic      overflow
);

    localparam int depth = `VID_FIFO_DEPTH;
    localparam int cred_w = $clog2(depth + 1);

    logic [cred_w-1:0] credits;
    logic              take;
    logic              wr_valid;
    pixel_t            wr_pixel;

    // A pixel is accepted only while a FIFO slot is reserved for it
    assign take = cam_href && (credits != '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_valid <= 1'b0;
            credits  <= cred_w'(depth);
            overflow <= 1'b0;
        end else begin
            wr_valid <= take;
            case ({credit_ret, take})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            // Sticky, pixel lost for lack of credit
            if (cam_href && (credits == '0)) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_pixel <= cam_data;
    end

    assign wr.valid = wr_valid;
    assign wr.pixel = wr_pixel;

    // Credits returned by the FIFO can never exceed what was handed out
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rstn) credits <= cred_w'(depth)
    ) else $error("cam_capture: credit count above FIFO depth");

endmodule : cam_capture

/* rtl/pixel_fifo.sv */
`timescale 1ns/10ps
`include "vid_macros.svh"

module pixel_fifo
    import vid_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  cam_beat_t wr,
    input  logic      pop,
    output pixel_t    rd_data,
    output logic      empty,
    output logic      credit_ret
);

    localparam int depth = `VID_FIFO_DEPTH;
    localparam int aw = $clog2(depth);

    pixel_t mem [depth];

    // Pointers carry one wrap bit above the address
    logic [aw:0] wptr;
    logic [aw:0] rptr;
    logic        full;

    assign empty = (wptr == rptr);
    assign full  = (wptr[aw] != rptr[aw]) && (wptr[aw-1:0] == rptr[aw-1:0]);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wptr       <= '0;
            rptr       <= '0;
            credit_ret <= 1'b0;
        end else begin
            if (wr.valid) begin
                wptr <= wptr + 1'b1;
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
            credit_ret <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            mem[wptr[aw-1:0]] <= wr.pixel;
        end
        // Head is presented the cycle after the pop
        if (pop) begin
            rd_data <= mem[rptr[aw-1:0]];
        end
    end

    // Credit flow in cam_capture must keep the writer off a full FIFO
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!rstn) wr.valid |-> !full
    ) else $error("pixel_fifo: write while full");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rstn) pop |-> !empty
    ) else $error("pixel_fifo: pop while empty");

endmodule : pixel_fifo

/* rtl/frame_lock.sv */
`timescale 1ns/10ps
`include "vid_macros.svh"

module frame_lock (
    input  logic clk,
    input  logic rstn,
    input  logic cam_href,
    output logic locked
);

    localparam int thresh = `VID_LOCK_THRESH;
    localparam int delay  = `VID_LOCK_DELAY;
    localparam int cnt_max = (thresh > delay) ? thresh : delay;
    localparam int cnt_w = $clog2(cnt_max + 1);

    // Blanking the lock threshold was tuned against
    localparam int h_blank_exp = 6;
    localparam int v_blank_exp = 3;

    if ((`VID_H_TOTAL - `VID_H_ACT != h_blank_exp) && (thresh != 0)) begin : g_h_blank_chk
        $error("frame_lock: horizontal blanking does not match lock threshold");
    end
    if ((`VID_V_TOTAL - `VID_V_ACT != v_blank_exp) && (thresh != 0)) begin : g_v_blank_chk
        $error("frame_lock: vertical blanking does not match lock threshold");
    end

    typedef enum logic [1:0] {
        st_search,
        st_wait,
        st_delay,
        st_locked
    } lock_state_e;

    lock_state_e      state;
    logic             href_d;
    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state  <= st_search;
            href_d <= 1'b1;
            cnt    <= '0;
            locked <= 1'b0;
        end else begin
            href_d <= cam_href;
            case (state)
                st_search: begin
                    // Falling edge of href opens a candidate blank
                    if (!cam_href && href_d) begin
                        state <= st_wait;
                        cnt   <= '0;
                    end
                end
                st_wait: begin
                    if (cam_href) begin
                        state <= st_search;
                    end else if (cnt == cnt_w'(thresh - 1)) begin
                        state <= st_delay;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_delay: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == cnt_w'(delay - 1)) begin
                        state  <= st_locked;
                        locked <= 1'b1;
                    end
                end
                default: begin
                    locked <= 1'b1;
                end
            endcase
        end
    end

    // Timing generator restarts only through reset
    a_lock_sticky: assert property (
        @(posedge clk) disable iff (!rstn) locked |=> locked
    ) else $error("frame_lock: locked fell without reset");

endmodule : frame_lock

/* rtl/video_timing.sv */
`timescale 1ns/10ps
`include "vid_macros.svh"

module video_timing
    import vid_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       locked,
    output disp_beat_t beat,
    output logic       rd_req
);

    localparam int x_w = `VID_X_W;
    localparam int y_w = `VID_Y_W;

    localparam int h_act     = `VID_H_ACT;
    localparam int h_sync_lo = `VID_H_ACT + `VID_H_FP;
    localparam int h_sync_hi = h_sync_lo + `VID_H_SYNC;
    localparam int h_total   = `VID_H_TOTAL;

    localparam int v_act     = `VID_V_ACT;
    localparam int v_sync_lo = `VID_V_ACT + `VID_V_FP;
    localparam int v_sync_hi = v_sync_lo + `VID_V_SYNC;
    localparam int v_total   = `VID_V_TOTAL;

    logic [x_w-1:0] hcnt;
    logic [y_w-1:0] vcnt;
    logic           h_active;
    logic           v_active;
    logic           h_sync;
    logic           v_sync;

    // Counters sit at the origin until the camera frame is locked
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (!locked) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == x_w'(h_total - 1)) begin
            hcnt <= '0;
            if (vcnt == y_w'(v_total - 1)) begin
                vcnt <= '0;
            end else begin
                vcnt <= vcnt + 1'b1;
            end
        end else begin
            hcnt <= hcnt + 1'b1;
        end
    end

    assign h_active = (hcnt < x_w'(h_act));
    assign v_active = (vcnt < y_w'(v_act));
    assign h_sync   = (hcnt >= x_w'(h_sync_lo)) && (hcnt < x_w'(h_sync_hi));
    assign v_sync   = (vcnt >= y_w'(v_sync_lo)) && (vcnt < y_w'(v_sync_hi));

    // The beat leaves one cycle behind the counters, so the request
    // from the current position lands one cycle ahead of its de
    assign rd_req = locked && h_active && v_active;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat <= '0;
        end else begin
            beat.vsync <= locked && v_sync;
            beat.hsync <= locked && h_sync;
            beat.de    <= rd_req;
            beat.x     <= hcnt;
            beat.y     <= vcnt;
            beat.pixel <= '0;
        end
    end

    a_x_range: assert property (
        @(posedge clk) disable iff (!rstn) beat.x < x_w'(h_total)
    ) else $error("video_timing: x beyond line length");

endmodule : video_timing

/* rtl/display_out.sv */
`timescale 1ns/10ps

module display_out
    import vid_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  disp_beat_t beat_in,
    input  logic       rd_req,
    input  logic       empty,
    input  pixel_t     rd_data,
    output logic       pop,
    output disp_beat_t disp,
    output logic       underflow
);

    logic req_q;
    logic served_q;

    assign pop = rd_req && !empty;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_q     <= 1'b0;
            served_q  <= 1'b0;
            disp      <= '0;
            underflow <= 1'b0;
        end else begin
            req_q    <= rd_req;
            served_q <= pop;

            disp <= beat_in;
            // FIFO head arrives together with the de beat it belongs to
            if (served_q) begin
                disp.pixel <= rd_data;
            end else begin
                disp.pixel <= '0;
            end

            if (req_q && !served_q) begin
                underflow <= 1'b1;
            end
        end
    end

endmodule : display_out

/* rtl/cam_display_top.sv */
`timescale 1ns/10ps

module cam_display_top
    import vid_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       cam_href,
    input  pixel_t     cam_data,
    output disp_beat_t disp,
    output logic       locked,
    output logic       overflow,
    output logic       underflow
);

    cam_beat_t  wr;
    logic       credit_ret;
    logic       pop;
    logic       empty;
    pixel_t     rd_data;
    disp_beat_t timing_beat;
    logic       rd_req;

    cam_capture u_cam_capture (
        .clk       (clk),
        .rstn      (rstn),
        .cam_href  (cam_href),
        .cam_data  (cam_data),
        .credit_ret(credit_ret),
        .wr        (wr),
        .overflow  (overflow)
    );

    pixel_fifo u_pixel_fifo (
        .clk       (clk),
        .rstn      (rstn),
        .wr        (wr),
        .pop       (pop),
        .rd_data   (rd_data),
        .empty     (empty),
        .credit_ret(credit_ret)
    );

    frame_lock u_frame_lock (
        .clk     (clk),
        .rstn    (rstn),
        .cam_href(cam_href),
        .locked  (locked)
    );

    video_timing u_video_timing (
        .clk   (clk),
        .rstn  (rstn),
        .locked(locked),
        .beat  (timing_beat),
        .rd_req(rd_req)
    );

    display_out u_display_out (
        .clk      (clk),
        .rstn     (rstn),
        .beat_in  (timing_beat),
        .rd_req   (rd_req),
        .empty    (empty),
        .rd_data  (rd_data),
        .pop      (pop),
        .disp     (disp),
        .underflow(underflow)
    );

endmodule : cam_display_top

/* dv/tb_cam_display.sv */
`timescale 1ns/10ps
`include "vid_macros.svh"

module tb_cam_display
    import vid_pkg::*;
;

    localparam int clk_period   = 20;
    localparam int h_act        = `VID_H_ACT;
    localparam int h_total      = `VID_H_TOTAL;
    localparam int h_sync_lo    = `VID_H_ACT + `VID_H_FP;
    localparam int v_act        = `VID_V_ACT;
    localparam int v_total      = `VID_V_TOTAL;
    localparam int v_sync_lo    = `VID_V_ACT + `VID_V_FP;
    localparam int frame_cycles = h_total * v_total;
    localparam int lock_cycles  = `VID_LOCK_THRESH + `VID_LOCK_DELAY;
    localparam int depth        = `VID_FIFO_DEPTH;
    // Six tests, each at most a frame plus lock and a FIFO fill, doubled for margin
    localparam int run_cycles   = 2 * (6 * frame_cycles + 6 * (lock_cycles + 2 * depth));
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    logic       clk;
    logic       rstn;
    logic       cam_href;
    pixel_t     cam_data;
    disp_beat_t disp;
    logic       locked;
    logic       overflow;
    logic       underflow;

    int          errors;
    int          checks;
    logic [31:0] lfsr_state;
    pixel_t      sent[$];

    cam_display_top u_cam_display_top (
        .clk      (clk),
        .rstn     (rstn),
        .cam_href (cam_href),
        .cam_data (cam_data),
        .disp     (disp),
        .locked   (locked),
        .overflow (overflow),
        .underflow(underflow)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ lfsr_taps;
        end
        return n;
    endfunction

    // One LFSR step per pixel bit
    function automatic pixel_t random_pixel();
        pixel_t p;
        for (int i = 0; i < `VID_PIX_W; i++) begin
            p[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        return p;
    endfunction

    task automatic check_value(input string test, input string field, input int expected,
                               input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("FAILED %s %s: expected %0h actual %0h", test, field, expected, actual);
        end
    endtask

    task automatic check_range(input string test, input string field, input int lo,
                               input int hi, input int actual);
        checks++;
        assert (actual >= lo && actual <= hi) else begin
            errors++;
            $display("FAILED %s %s: expected %0d..%0d actual %0d", test, field, lo, hi, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rstn     <= 1'b0;
        cam_href <= 1'b0;
        cam_data <= '0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        sent.delete();
    endtask

    task automatic wait_locked(input string test, input int limit, output int cycles);
        cycles = 0;
        while (!locked && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (locked) else begin
            report_failure($sformatf("%s: locked did not rise within %0d cycles", test, limit));
        end
    endtask

    task automatic wait_de(input string test, input int limit, output int cycles);
        cycles = 0;
        while (!disp.de && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (disp.de) else begin
            report_failure($sformatf("%s: no display data enable within %0d cycles", test, limit));
        end
    endtask

    task automatic send_pixel();
        pixel_t p;
        @(posedge clk);
        p = random_pixel();
        cam_href <= 1'b1;
        cam_data <= p;
        sent.push_back(p);
    endtask

    // Starts on the first de cycle and walks one display frame
    task automatic compare_frame_pixels(input string test, input int count);
        int shown;
        shown = 0;
        for (int pos = 0; pos < frame_cycles; pos++) begin
            if (pos != 0) begin
                @(negedge clk);
            end
            if (disp.de && shown < count) begin
                assert (sent.size() != 0) else begin
                    report_failure($sformatf("%s: more pixels shown than sent", test));
                end
                if (sent.size() != 0) begin
                    check_value(test, "pixel", sent.pop_front(), disp.pixel);
                end
                shown++;
            end
        end
        check_value(test, "pixels shown", count, shown);
        check_value(test, "underflow", 0, underflow);
    endtask

    task automatic test_reset();
        apply_reset();
        @(negedge clk);
        check_value("test_reset", "locked", 0, locked);
        check_value("test_reset", "overflow", 0, overflow);
        check_value("test_reset", "underflow", 0, underflow);
        check_value("test_reset", "vsync", 0, disp.vsync);
        check_value("test_reset", "hsync", 0, disp.hsync);
        check_value("test_reset", "de", 0, disp.de);
        check_value("test_reset", "x", 0, disp.x);
        check_value("test_reset", "y", 0, disp.y);
        check_value("test_reset", "pixel", 0, disp.pixel);
    endtask

    task automatic test_lock();
        int cycles;
        apply_reset();
        @(posedge clk);
        cam_href <= 1'b1;
        repeat (4) @(posedge clk);
        // Short gap, well under the blank threshold
        cam_href <= 1'b0;
        repeat (`VID_LOCK_THRESH / 2) @(posedge clk);
        cam_href <= 1'b1;
        repeat (lock_cycles + 2) @(posedge clk);
        @(negedge clk);
        check_value("test_lock", "locked after short gap", 0, locked);
        @(posedge clk);
        cam_href <= 1'b0;
        wait_locked("test_lock", lock_cycles + 10, cycles);
        check_range("test_lock", "cycles to lock", lock_cycles, lock_cycles + 4, cycles);
    endtask

    task automatic test_frame_timing();
        int cycles;
        int ex;
        int ey;
        int line_de;
        int lines;
        int hs;
        int vs;
        string name;
        name = "test_frame_timing";
        line_de = 0;
        lines = 0;
        hs = 0;
        vs = 0;
        apply_reset();
        wait_locked(name, lock_cycles + 10, cycles);
        wait_de(name, 8, cycles);
        check_value(name, "cycles from lock to first de", 2, cycles);
        for (int pos = 0; pos < frame_cycles; pos++) begin
            ex = pos % h_total;
            ey = pos / h_total;
            check_value(name, "x", ex, disp.x);
            check_value(name, "y", ey, disp.y);
            check_value(name, "de", int'(ex < h_act && ey < v_act), disp.de);
            check_value(name, "hsync", int'(ex >= h_sync_lo && ex < h_sync_lo + `VID_H_SYNC),
                        disp.hsync);
            check_value(name, "vsync", int'(ey >= v_sync_lo && ey < v_sync_lo + `VID_V_SYNC),
                        disp.vsync);
            line_de += disp.de;
            hs += disp.hsync;
            vs += disp.vsync;
            if (ex == h_total - 1) begin
                if (line_de != 0) begin
                    check_value(name, "de per line", h_act, line_de);
                    lines++;
                end
                line_de = 0;
            end
            @(negedge clk);
        end
        check_value(name, "active lines", v_act, lines);
        check_value(name, "hsync cycles", `VID_H_SYNC * v_total, hs);
        check_value(name, "vsync cycles", `VID_V_SYNC * h_total, vs);
    endtask

    task automatic test_pixel_order();
        int cycles;
        apply_reset();
        for (int line = 0; line < v_act; line++) begin
            for (int i = 0; i < h_act; i++) begin
                send_pixel();
            end
            @(posedge clk);
            cam_href <= 1'b0;
            repeat (3) @(posedge clk);
        end
        wait_locked("test_pixel_order", lock_cycles + 10, cycles);
        wait_de("test_pixel_order", 8, cycles);
        compare_frame_pixels("test_pixel_order", h_act * v_act);
        check_value("test_pixel_order", "overflow", 0, overflow);
    endtask

    task automatic test_underflow();
        int cycles;
        apply_reset();
        wait_locked("test_underflow", lock_cycles + 10, cycles);
        check_value("test_underflow", "underflow at lock", 0, underflow);
        wait_de("test_underflow", 8, cycles);
        check_value("test_underflow", "underflow", 1, underflow);
        check_value("test_underflow", "pixel", 0, disp.pixel);
    endtask

    task automatic test_overflow();
        int cycles;
        apply_reset();
        for (int i = 0; i < depth + 8; i++) begin
            send_pixel();
        end
        @(posedge clk);
        cam_href <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("test_overflow", "overflow", 1, overflow);
        wait_locked("test_overflow", lock_cycles + 10, cycles);
        wait_de("test_overflow", 8, cycles);
        compare_frame_pixels("test_overflow", depth);
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        cam_href = 1'b0;
        cam_data = '0;
        errors = 0;
        checks = 0;
        lfsr_state = 32'hf737;
        test_reset();
        test_lock();
        test_frame_timing();
        test_pixel_order();
        test_underflow();
        test_overflow();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(run_cycles * clk_period);
        $display("Simulation did not finish within %0d cycles", run_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule : tb_cam_display

/* tb.f */
+incdir+rtl
rtl/vid_pkg.sv
rtl/cam_capture.sv
rtl/pixel_fifo.sv
rtl/frame_lock.sv
rtl/video_timing.sv
rtl/display_out.sv
rtl/cam_display_top.sv
dv/tb_cam_display.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f tb.f --top-module tb_cam_display

result=$(./obj_dir/Vtb_cam_display) || true
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx 'STATUS: PASS'; then
    exit 0
fi
exit 1
